// ==== src/switch_pkg.sv ====
`default_nettype none

package switch_pkg;

    // One byte of an incoming byte stream
    typedef logic [7:0] byte_t;

    // Bytes per packet
    localparam int pkt_bytes = 8;

    //------------------------------
    // Packet word
    //------------------------------

    // Whole word for RAM and outputs, byte lanes for assembly
    typedef union packed {
        logic [pkt_bytes*8-1:0]  word;
        byte_t [pkt_bytes-1:0]   bytes;
    } pkt_word_t;

    //------------------------------
    // Default sizes
    //------------------------------

    // Four ports
    localparam int default_dest_width = 2;

    // Sixteen packet slots
    localparam int default_addr_width = 4;

endpackage

`default_nettype wire

// ==== src/dequeue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dequeue_if import switch_pkg::*;
#(
    parameter int n_ports = 1 << default_dest_width
)
();

    logic [n_ports-1:0] list_empty;
    // One-hot grant that removes the head of the granted list
    logic [n_ports-1:0] deq_grant;
    logic               rd_valid;
    pkt_word_t          rd_pkt;

    modport buffer_mp (output list_empty, output rd_valid, output rd_pkt, input deq_grant);

    modport egress_mp (input list_empty, input rd_valid, input rd_pkt, output deq_grant);

endinterface

`default_nettype wire

// ==== src/byte_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_assembler import switch_pkg::*;
#(
    parameter int dest_width = default_dest_width
)
(
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  dest_valid,
    input  logic [dest_width-1:0] dest,
    input  logic                  byte_valid,
    input  byte_t                 byte_data,
    output logic                  pkt_valid,
    input  logic                  grant,
    output pkt_word_t             pkt,
    output logic [dest_width-1:0] pkt_dest
);

    logic [pkt_bytes-1:0]  lane;
    logic [dest_width-1:0] cur_dest;
    pkt_word_t             asm_q;
    pkt_word_t             asm_next;
    logic                  pkt_done;

    assign pkt_done = byte_valid && lane[pkt_bytes-1];

    // Destination for the packet being assembled
    always_ff @(posedge clock)
    begin
        if (dest_valid)
            cur_dest <= dest;
    end

    // One-hot byte position that rotates on every byte
    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
            lane <= pkt_bytes'(1);
        else if (byte_valid)
            lane <= {lane[pkt_bytes-2:0], lane[pkt_bytes-1]};
    end

    always_comb
    begin
        asm_next = asm_q;
        for (int i = 0; i < pkt_bytes; i++)
            if (byte_valid && lane[i])
                asm_next.bytes[i] = byte_data;
    end

    //------------------------------
    // Completed packet
    //------------------------------

    always_ff @(posedge clock)
    begin
        asm_q <= asm_next;
        if (pkt_done)
        begin
            pkt      <= asm_next;
            pkt_dest <= cur_dest;
        end
    end

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
            pkt_valid <= 1'b0;
        else if (pkt_done)
            pkt_valid <= 1'b1;
        else if (grant)
            pkt_valid <= 1'b0;
    end

    // The sender must not outrun the input arbiter
    assert property (@(posedge clock) disable iff (!reset_n)
        pkt_done |-> (!pkt_valid || grant))
        else $error("byte_assembler: packet completed over an ungranted one");

endmodule

`default_nettype wire

// ==== src/round_robin_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module round_robin_arbiter
#(
    parameter int n_ports = 4
)
(
    input  logic               clock,
    input  logic               reset_n,
    input  logic [n_ports-1:0] req,
    output logic [n_ports-1:0] grant
);

    localparam int ptr_w = $clog2(n_ports);

    logic [ptr_w-1:0]     ptr;
    logic [ptr_w-1:0]     ptr_next;
    logic [2*n_ports-1:0] req_double;
    logic [n_ports-1:0]   req_rot;
    logic [n_ports-1:0]   grant_rot;
    logic [2*n_ports-1:0] grant_double;

    // Rotate so the port at ptr sits in bit 0
    assign req_double   = {req, req} >> ptr;
    assign req_rot      = req_double[n_ports-1:0];

    // Lowest set bit has the highest priority
    assign grant_rot    = req_rot & ~(req_rot - 1'b1);

    // Rotate back to port order
    assign grant_double = {grant_rot, grant_rot} << ptr;
    assign grant        = grant_double[2*n_ports-1:n_ports];

    always_comb
    begin
        ptr_next = ptr;
        for (int i = 0; i < n_ports; i++)
            if (grant[i])
                ptr_next = ptr_w'((i + 1) % n_ports);
    end

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
            ptr <= '0;
        else
            ptr <= ptr_next;
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        $onehot0(grant) && ((grant & ~req) == '0))
        else $error("round_robin_arbiter: bad grant %b for req %b", grant, req);

endmodule

`default_nettype wire

// ==== src/pkt_ingress.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_ingress import switch_pkg::*;
#(
    parameter  int dest_width = default_dest_width,
    localparam int n_ports    = 1 << dest_width
)
(
    input  logic                                clock,
    input  logic                                reset_n,
    input  logic [n_ports-1:0]                  dest_valid,
    input  logic [n_ports-1:0][dest_width-1:0]  dest,
    input  logic [n_ports-1:0]                  byte_valid,
    input  byte_t [n_ports-1:0]                 byte_data,
    input  logic                                full,
    output logic                                enq_valid,
    output logic [dest_width-1:0]               enq_dest,
    output pkt_word_t                           enq_pkt
);

    logic [n_ports-1:0]                 asm_valid;
    logic [n_ports-1:0]                 req;
    logic [n_ports-1:0]                 grant;
    pkt_word_t [n_ports-1:0]            asm_pkt;
    logic [n_ports-1:0][dest_width-1:0] asm_dest;

    for (genvar i = 0; i < n_ports; i++)
    begin : g_asm
        byte_assembler #(.dest_width(dest_width)) asm_i (
            .clock      (clock),
            .reset_n    (reset_n),
            .dest_valid (dest_valid[i]),
            .dest       (dest[i]),
            .byte_valid (byte_valid[i]),
            .byte_data  (byte_data[i]),
            .pkt_valid  (asm_valid[i]),
            .grant      (grant[i]),
            .pkt        (asm_pkt[i]),
            .pkt_dest   (asm_dest[i])
        );
    end

    // Nothing is admitted while the packet memory is full
    assign req = asm_valid & {n_ports{!full}};

    round_robin_arbiter #(.n_ports(n_ports)) arb_i (
        .clock   (clock),
        .reset_n (reset_n),
        .req     (req),
        .grant   (grant)
    );

    assign enq_valid = |grant;

    always_comb
    begin
        enq_pkt  = '0;
        enq_dest = '0;
        for (int i = 0; i < n_ports; i++)
            if (grant[i])
            begin
                enq_pkt  = asm_pkt[i];
                enq_dest = asm_dest[i];
            end
    end

endmodule

`default_nettype wire

// ==== src/dual_port_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram
#(
    parameter int addr_width = 4,
    parameter int data_width = 64
)
(
    input  logic                  clock,
    input  logic                  rd_en,
    input  logic [addr_width-1:0] rd_addr,
    output logic [data_width-1:0] rd_data,
    input  logic                  wr_en,
    input  logic [addr_width-1:0] wr_addr,
    input  logic [data_width-1:0] wr_data
);

    logic [data_width-1:0] mem [1 << addr_width];

    always_ff @(posedge clock)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;

        // Same-address write is forwarded to the read port
        if (rd_en)
        begin
            if (wr_en && (rd_addr == wr_addr))
                rd_data <= wr_data;
            else
                rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== src/pkt_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_buffer import switch_pkg::*;
#(
    parameter  int dest_width = default_dest_width,
    parameter  int addr_width = default_addr_width,
    localparam int n_ports    = 1 << dest_width,
    localparam int mem_size   = 1 << addr_width
)
(
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  enq_valid,
    input  logic [dest_width-1:0] enq_dest,
    input  pkt_word_t             enq_pkt,
    output logic                  full,
    output logic                  stop_sending_packets,
    dequeue_if.buffer_mp          deq
);

    localparam int cnt_w = addr_width + 1;

    logic [n_ports-1:0]           enq_sel;
    logic                         enq_to_empty;
    logic                         deq_any;
    logic [dest_width-1:0]        deq_idx;
    logic [addr_width-1:0]        deq_addr;
    logic [n_ports-1:0]           grant_q;
    logic [cnt_w-1:0]             free_count;
    logic [cnt_w-1:0]             fresh_cnt;
    logic [addr_width-1:0]        ring [mem_size];
    logic [addr_width-1:0]        ring_rd;
    logic [addr_width-1:0]        ring_wr;
    logic [addr_width-1:0]        alloc_addr;
    logic [cnt_w-1:0]             len  [n_ports];
    logic [addr_width-1:0]        head [n_ports];
    logic [addr_width-1:0]        tail [n_ports];
    logic [$bits(pkt_word_t)-1:0] data_rd;
    logic [addr_width-1:0]        next_rd;

    assign enq_sel      = {{(n_ports-1){1'b0}}, enq_valid} << enq_dest;
    assign enq_to_empty = (len[enq_dest] == '0);
    assign deq_any      = |deq.deq_grant;
    assign deq_addr     = head[deq_idx];

    always_comb
    begin
        deq_idx = '0;
        for (int i = 0; i < n_ports; i++)
            if (deq.deq_grant[i])
                deq_idx = dest_width'(i);
    end

    //------------------------------
    // Free addresses
    //------------------------------

    // Never-used addresses first, then the ring of returned ones
    assign alloc_addr = fresh_cnt[addr_width] ? ring[ring_rd] : fresh_cnt[addr_width-1:0];

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            free_count <= cnt_w'(mem_size);
            fresh_cnt  <= '0;
            ring_rd    <= '0;
            ring_wr    <= '0;
        end
        else
        begin
            free_count <= free_count + cnt_w'(deq_any) - cnt_w'(enq_valid);
            if (enq_valid && fresh_cnt[addr_width])
                ring_rd <= ring_rd + 1'b1;
            else if (enq_valid)
                fresh_cnt <= fresh_cnt + 1'b1;
            if (deq_any)
                ring_wr <= ring_wr + 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (deq_any)
            ring[ring_wr] <= deq_addr;
    end

    assign full                 = (free_count == '0);
    assign stop_sending_packets = (free_count <= cnt_w'(2 * n_ports));

    //------------------------------
    // Per-port lists
    //------------------------------

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            grant_q <= '0;
            for (int i = 0; i < n_ports; i++)
                len[i] <= '0;
        end
        else
        begin
            grant_q <= deq.deq_grant;
            for (int i = 0; i < n_ports; i++)
                len[i] <= len[i] + cnt_w'(enq_sel[i]) - cnt_w'(deq.deq_grant[i]);
        end
    end

    // A packet into an empty list wins over the pending next pointer
    always_ff @(posedge clock)
    begin
        for (int i = 0; i < n_ports; i++)
        begin
            if (enq_sel[i])
                tail[i] <= alloc_addr;
            if (enq_sel[i] && enq_to_empty)
                head[i] <= alloc_addr;
            else if (grant_q[i])
                head[i] <= next_rd;
        end
    end

    always_comb
    begin
        for (int i = 0; i < n_ports; i++)
            deq.list_empty[i] = (len[i] == '0);
    end

    dual_port_ram #(.addr_width(addr_width), .data_width($bits(pkt_word_t))) data_ram (
        .clock   (clock),
        .rd_en   (deq_any),
        .rd_addr (deq_addr),
        .rd_data (data_rd),
        .wr_en   (enq_valid),
        .wr_addr (alloc_addr),
        .wr_data (enq_pkt.word)
    );

    // Links the old tail to the new packet
    dual_port_ram #(.addr_width(addr_width), .data_width(addr_width)) next_ram (
        .clock   (clock),
        .rd_en   (deq_any),
        .rd_addr (deq_addr),
        .rd_data (next_rd),
        .wr_en   (enq_valid && !enq_to_empty),
        .wr_addr (tail[enq_dest]),
        .wr_data (alloc_addr)
    );

    assign deq.rd_valid = |grant_q;
    assign deq.rd_pkt   = data_rd;

    assert property (@(posedge clock) disable iff (!reset_n) enq_valid |-> !full)
        else $error("pkt_buffer: enqueue while full");

endmodule

`default_nettype wire

// ==== src/pkt_egress.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_egress import switch_pkg::*;
#(
    parameter  int dest_width = default_dest_width,
    localparam int n_ports    = 1 << dest_width
)
(
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic [n_ports-1:0]      pkt_ready,
    dequeue_if.egress_mp            deq,
    output logic [n_ports-1:0]      pkt_valid,
    output pkt_word_t [n_ports-1:0] pkt
);

    logic [n_ports-1:0] req;
    logic [n_ports-1:0] grant;
    logic [n_ports-1:0] grant_q;

    // Skip a port granted last cycle so its head pointer can settle
    assign req = ~deq.list_empty & pkt_ready & ~grant_q;

    round_robin_arbiter #(.n_ports(n_ports)) arb_i (
        .clock   (clock),
        .reset_n (reset_n),
        .req     (req),
        .grant   (grant)
    );

    assign deq.deq_grant = grant;

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
            grant_q <= '0;
        else
            grant_q <= grant;
    end

    assign pkt_valid = grant_q;

    // The read word goes to every port and pkt_valid picks the owner
    for (genvar i = 0; i < n_ports; i++)
    begin : g_out
        assign pkt[i] = deq.rd_pkt;
    end

    assert property (@(posedge clock) disable iff (!reset_n) deq.rd_valid == (|grant_q))
        else $error("pkt_egress: read data out of step with grant");

endmodule

`default_nettype wire

// ==== src/switch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_top import switch_pkg::*;
#(
    parameter  int dest_width = default_dest_width,
    parameter  int addr_width = default_addr_width,
    localparam int n_ports    = 1 << dest_width
)
(
    input  logic                               clock,
    input  logic                               reset_n,
    input  logic [n_ports-1:0]                 dest_valid,
    input  logic [n_ports-1:0][dest_width-1:0] dest,
    input  logic [n_ports-1:0]                 byte_valid,
    input  byte_t [n_ports-1:0]                byte_data,
    input  logic [n_ports-1:0]                 pkt_ready,
    output logic [n_ports-1:0]                 pkt_valid,
    output pkt_word_t [n_ports-1:0]            pkt,
    output logic                               stop_sending_packets,
    output logic                               memory_is_full
);

    logic                  enq_valid;
    logic [dest_width-1:0] enq_dest;
    pkt_word_t             enq_pkt;

    dequeue_if #(.n_ports(n_ports)) deq_bus ();

    //------------------------------
    // Input side
    //------------------------------

    pkt_ingress #(.dest_width(dest_width)) ingress_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .dest_valid (dest_valid),
        .dest       (dest),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .full       (memory_is_full),
        .enq_valid  (enq_valid),
        .enq_dest   (enq_dest),
        .enq_pkt    (enq_pkt)
    );

    pkt_buffer #(.dest_width(dest_width), .addr_width(addr_width)) buffer_i (
        .clock                (clock),
        .reset_n              (reset_n),
        .enq_valid            (enq_valid),
        .enq_dest             (enq_dest),
        .enq_pkt              (enq_pkt),
        .full                 (memory_is_full),
        .stop_sending_packets (stop_sending_packets),
        .deq                  (deq_bus.buffer_mp)
    );

    //------------------------------
    // Output side
    //------------------------------

    pkt_egress #(.dest_width(dest_width)) egress_i (
        .clock     (clock),
        .reset_n   (reset_n),
        .pkt_ready (pkt_ready),
        .deq       (deq_bus.egress_mp),
        .pkt_valid (pkt_valid),
        .pkt       (pkt)
    );

endmodule

`default_nettype wire

// ==== bench/switch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_tb import switch_pkg::*;
();

    localparam int    dest_width  = default_dest_width;
    localparam int    n_ports     = 1 << dest_width;
    localparam int    stop_window = 20;
    localparam string golden_path = "bench/switch_golden.txt";

    logic                               clock;
    logic                               reset_n;
    logic [n_ports-1:0]                 dest_valid;
    logic [n_ports-1:0][dest_width-1:0] dest;
    logic [n_ports-1:0]                 byte_valid;
    byte_t [n_ports-1:0]                byte_data;
    logic [n_ports-1:0]                 pkt_ready;
    logic [n_ports-1:0]                 pkt_valid;
    pkt_word_t [n_ports-1:0]            pkt;
    logic                               stop_sending_packets;
    logic                               memory_is_full;

    // Commands parsed from the golden file
    byte         cmd_kind [$];
    int          cmd_arg [$];
    int          cmd_dest [$];
    logic [63:0] cmd_word [$];
    string       cmd_name [$];

    // Scoreboard with one queue per source and destination pair
    logic [63:0] exp_q [n_ports*n_ports][$];
    logic [63:0] src_word_q [n_ports][$];
    int          src_dest_q [n_ports][$];
    logic [63:0] cur_word [n_ports];
    int          byte_pos [n_ports];

    string              test_name       = "reset";
    integer             seed            = 32'h818;
    int                 value_errors    = 0;
    int                 protocol_errors = 0;
    int                 pending         = 0;
    int                 limit           = 0;
    int                 cycle_count     = 0;
    bit                 random_ready    = 1'b0;
    bit                 golden_ok       = 1'b0;
    logic [n_ports-1:0] ready_last      = '0;

    switch_top #(.dest_width(dest_width), .addr_width(default_addr_width)) dut_i (
        .clock                (clock),
        .reset_n              (reset_n),
        .dest_valid           (dest_valid),
        .dest                 (dest),
        .byte_valid           (byte_valid),
        .byte_data            (byte_data),
        .pkt_ready            (pkt_ready),
        .pkt_valid            (pkt_valid),
        .pkt                  (pkt),
        .stop_sending_packets (stop_sending_packets),
        .memory_is_full       (memory_is_full)
    );

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    //------------------------------
    // Golden file
    //------------------------------

    task automatic read_golden();
        int          fd;
        int          n;
        int          want;
        int          a;
        int          b;
        int          budget;
        logic [63:0] w;
        string       line;
        string       name;
        budget = 0;
        fd = $fopen(golden_path, "r");
        golden_ok = (fd != 0);
        while (golden_ok && $fgets(line, fd) != 0)
        begin
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n")
                continue;
            a    = 0;
            b    = 0;
            w    = '0;
            name = "";
            n    = 0;
            want = 1;
            case (line.getc(0))
                "T": n = $sscanf(line, "T %s", name);
                "R": n = $sscanf(line, "R %h", a);
                "W": n = $sscanf(line, "W %d", a);
                "D": n = $sscanf(line, "D %d", a);
                "P":
                begin
                    want = 3;
                    n = $sscanf(line, "P %d %d %h", a, b, w);
                    if (a >= n_ports || b >= n_ports)
                        n = 0;
                    budget += pkt_bytes;
                end
                "G", "N", "S": want = 0;
                default: want = -1;
            endcase
            // Drain and wait lengths count toward the cycle limit
            if (line.getc(0) == "W" || line.getc(0) == "D")
                budget += a;
            if (line.getc(0) == "S")
                budget += stop_window;
            assert (n == want)
            else
            begin
                protocol_errors++;
                $display("Malformed golden line %s", line);
            end
            cmd_kind.push_back(line.getc(0));
            cmd_arg.push_back(a);
            cmd_dest.push_back(b);
            cmd_word.push_back(w);
            cmd_name.push_back(name);
        end
        if (golden_ok)
            $fclose(fd);
        limit = 2 * budget + 200;
    endtask

    //------------------------------
    // Cycle step and output checks
    //------------------------------

    task automatic check_delivery(input int port);
        int          src;
        int          key;
        logic [63:0] expected;
        src = int'(pkt[port].word[63:60]);
        key = src * n_ports + port;
        assert (ready_last[port])
        else
        begin
            protocol_errors++;
            $display("%s: pulse on port %0d while it was not ready", test_name, port);
        end
        assert (src < n_ports && exp_q[key].size() != 0)
        else
        begin
            protocol_errors++;
            $display("%s: unexpected packet %h on port %0d", test_name, pkt[port].word, port);
        end
        if (src < n_ports && exp_q[key].size() != 0)
        begin
            expected = exp_q[key].pop_front();
            pending--;
            assert (pkt[port].word == expected)
            else
            begin
                value_errors++;
                $display("FAILED %s: port %0d expected %h actual %h",
                         test_name, port, expected, pkt[port].word);
            end
        end
    endtask

    task automatic check_outputs();
        assert (!memory_is_full)
        else
        begin
            protocol_errors++;
            $display("%s: memory_is_full went high", test_name);
        end
        for (int p = 0; p < n_ports; p++)
            if (pkt_valid[p])
                check_delivery(p);
        // Ready seen by the egress arbiter at the edge that ends this cycle
        ready_last = pkt_ready;
    endtask

    // Outputs checked at the falling edge, inputs driven just after the rising edge
    task automatic next_cycle();
        @(negedge clock);
        check_outputs();
        @(posedge clock);
        #5;
        dest_valid = '0;
        byte_valid = '0;
        if (random_ready)
            pkt_ready = n_ports'($random(seed));
    endtask

    //------------------------------
    // Stimulus
    //------------------------------

    task automatic start_packet(input int src);
        int dst;
        cur_word[src] = src_word_q[src].pop_front();
        dst = src_dest_q[src].pop_front();
        dest_valid[src] = 1'b1;
        dest[src] = dest_width'(dst);
        exp_q[src*n_ports + dst].push_back(cur_word[src]);
        pending++;
        byte_pos[src] = 0;
    endtask

    // All sources send in parallel with the first byte in the same cycle as the destination
    task automatic send_queued();
        bit busy;
        busy = 1'b1;
        while (busy)
        begin
            next_cycle();
            busy = 1'b0;
            for (int s = 0; s < n_ports; s++)
            begin
                if (byte_pos[s] == pkt_bytes && src_word_q[s].size() != 0 &&
                    !stop_sending_packets)
                    start_packet(s);
                if (byte_pos[s] < pkt_bytes)
                begin
                    byte_valid[s] = 1'b1;
                    byte_data[s] = cur_word[s][byte_pos[s]*8 +: 8];
                    byte_pos[s]++;
                end
                if (byte_pos[s] < pkt_bytes || src_word_q[s].size() != 0)
                    busy = 1'b1;
            end
        end
    endtask

    task automatic await_stop();
        int n;
        n = 0;
        while (!stop_sending_packets && n < stop_window)
        begin
            next_cycle();
            n++;
        end
        assert (stop_sending_packets)
        else
        begin
            protocol_errors++;
            $display("%s: stop_sending_packets did not rise within %0d cycles of the last byte",
                     test_name, stop_window);
        end
    endtask

    task automatic drain();
        while (pending != 0)
            next_cycle();
        next_cycle();
        assert (!stop_sending_packets)
        else
        begin
            protocol_errors++;
            $display("%s: stop_sending_packets still high with the memory drained", test_name);
        end
    endtask

    task automatic check_reset_state();
        assert (pkt_valid == '0)
        else
        begin
            value_errors++;
            $display("FAILED %s: pkt_valid expected %b actual %b",
                     test_name, n_ports'(0), pkt_valid);
        end
        assert (!stop_sending_packets && !memory_is_full)
        else
        begin
            value_errors++;
            $display("FAILED %s: stop and full expected 00 actual %b%b",
                     test_name, stop_sending_packets, memory_is_full);
        end
    endtask

    task automatic run_commands();
        for (int i = 0; i < cmd_kind.size(); i++)
        begin
            case (cmd_kind[i])
                "T": test_name = cmd_name[i];
                "R":
                begin
                    random_ready = 1'b0;
                    pkt_ready = n_ports'(cmd_arg[i]);
                end
                "N": random_ready = 1'b1;
                "P":
                begin
                    src_word_q[cmd_arg[i]].push_back(cmd_word[i]);
                    src_dest_q[cmd_arg[i]].push_back(cmd_dest[i]);
                end
                "G": send_queued();
                "W": repeat (cmd_arg[i]) next_cycle();
                "S": await_stop();
                "D": drain();
                default: ;
            endcase
        end
    endtask

    //------------------------------
    // Run control
    //------------------------------

    initial
    begin
        wait (limit != 0);
        while (cycle_count < limit)
        begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the run did not finish", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        reset_n    = 1'b0;
        dest_valid = '0;
        dest       = '0;
        byte_valid = '0;
        byte_data  = '0;
        pkt_ready  = '0;
        for (int p = 0; p < n_ports; p++)
            byte_pos[p] = pkt_bytes;
        read_golden();
        if (!golden_ok)
        begin
            $display("Could not open %s", golden_path);
            $display("TEST RESULT: FAIL");
            $finish;
        end
        else
        begin
            repeat (8) @(posedge clock);
            #5;
            reset_n = 1'b1;
            check_reset_state();
            run_commands();
            // Late or repeated pulses still reach the scoreboard
            test_name = "idle";
            repeat (10) next_cycle();
            $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
            if (value_errors + protocol_errors == 0)
                $display("TEST RESULT: PASS");
            else
                $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/switch_pkg.sv
src/dequeue_if.sv
src/byte_assembler.sv
src/round_robin_arbiter.sv
src/pkt_ingress.sv
src/dual_port_ram.sv
src/pkt_buffer.sv
src/pkt_egress.sv
src/switch_top.sv
bench/switch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds switch_tb with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -j 0 --top-module switch_tb -f build.f -o switch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/switch_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1

// ==== bench/switch_golden.txt ====
# Line kinds are T name, R ready_mask, N for random ready, P src dest word, G to send,
# W cycles to wait, S to await stop and D drain_budget. A word's top byte is src then seq
T single
R f
P 0 2 0088776655443322
G
D 40
T merge
P 0 1 01f0e1d2c3b4a596
P 1 1 1011223344556677
P 2 1 2001020304050607
P 3 1 30a0b0c0d0e0f001
P 0 1 02f1e2d3c4b5a697
P 1 1 1187654321fedcba
G
D 80
T hold
R d
P 2 1 215a5a5a5a5a5a5a
P 2 1 22a5a5a5a5a5a5a5
P 3 0 310f1e2d3c4b5a69
G
W 30
R f
D 40
T fill
R 0
P 0 3 0310203040506070
P 1 2 1201234567890abc
P 2 0 23fedcba98765432
P 3 1 3255aa55aa55aa55
P 0 1 04aa55aa55aa55aa
P 1 0 1300ff00ff00ff00
P 2 3 24ff00ff00ff00ff
P 3 2 3313579bdf02468a
G
S
R f
D 60
T random
N
P 0 3 05c3c3c3c3c3c3c3
P 1 0 143c3c3c3c3c3c3c
P 2 2 2596969696969696
P 3 3 3469696969696969
P 0 0 06e7e7e7e7e7e7e7
P 1 1 157e7e7e7e7e7e7e
G
D 200
